// ==== hdl/cps_mmr_params.svh ====
`ifndef CPS_MMR_PARAMS_SVH
`define CPS_MMR_PARAMS_SVH

// length of the per-game configuration string
`define CPSB_CFG_BYTES 24

// a multiplier or priority address with this code is absent
// on that game; the cpu word address 1f never hits a register either
`define CPSB_ADDR_OFF 5'h1f

// value seen when nothing drives the read bus
`define MMR_OPEN_BUS 16'hffff

// reset values
`define CPS_A_RST 16'h0000

// layer order after reset
`define LAYER_CTRL_RST 16'h12ce

// all six palette pages copied after reset
`define PAL_PAGE_RST 6'h3f

`define PRIO_RST 16'h0000

`endif

// ==== hdl/cps_mmr_pkg.sv ====
package cps_mmr_pkg;

    // cpu side of both chips, word address and active-low byte strobes
    typedef struct packed {
        logic [4:0]  addr;
        logic [1:0]  dsn;
        logic [15:0] data;
    } cpu_bus_t;

    // extra player inputs read through the cps_b chip
    typedef struct packed {
        logic [3:0] start_button;
        logic [3:0] coin_input;
        logic [7:0] joystick3;
        logic [7:0] joystick4;
    } player_in_t;

    // write-only cps_a registers
    typedef struct packed {
        logic [15:0] vram_obj_base;
        logic [15:0] vram1_base;
        logic [15:0] vram2_base;
        logic [15:0] vram3_base;
        logic [15:0] vram_row_base;
        logic [15:0] pal_base;
        logic [15:0] hpos1;
        logic [15:0] hpos2;
        logic [15:0] hpos3;
        logic [15:0] vpos1;
        logic [15:0] vpos2;
        logic [15:0] vpos3;
        logic [15:0] hstar1;
        logic [15:0] hstar2;
        logic [15:0] vstar1;
        logic [15:0] vstar2;
        logic [15:0] row_offset;
        logic [15:0] ppu_ctrl;
    } cps_a_out_t;

    typedef struct packed {
        logic [15:0] layer_ctrl;
        logic [15:0] prio0;
        logic [15:0] prio1;
        logic [15:0] prio2;
        logic [15:0] prio3;
        logic [5:0]  pal_page_en;
    } cps_b_out_t;

    // per-game word addresses of the cps_b registers
    typedef struct packed {
        logic [4:0] id;
        logic [4:0] mult1;
        logic [4:0] mult2;
        logic [4:0] rslt0;
        logic [4:0] rslt1;
        logic [4:0] layer;
        logic [4:0] prio0;
        logic [4:0] prio1;
        logic [4:0] prio2;
        logic [4:0] prio3;
        logic [4:0] in2;
        logic [4:0] in3;
        logic [4:0] pal_page;
    } cpsb_map_t;

    typedef struct packed {
        logic [7:0]  id;
        logic [7:0]  mask0;
        logic [7:0]  mask1;
        logic [7:0]  mask2;
        logic [7:0]  mask3;
        logic [7:0]  mask4;
        logic [5:0]  game;
        logic [15:0] bank_offset;
        logic [15:0] bank_mask;
        logic        cpu_speed;
    } mapper_t;

    // which cps_b register an access hits
    typedef enum logic [3:0] {
        cpsb_id, cpsb_mult1, cpsb_mult2, cpsb_rslt0, cpsb_rslt1,
        cpsb_layer, cpsb_prio0, cpsb_prio1, cpsb_prio2, cpsb_prio3,
        cpsb_pal_page, cpsb_in2, cpsb_in3, cpsb_none
    } cpsb_reg_e;

endpackage

// ==== hdl/cpsb_config.sv ====
`timescale 1ns/1ns
`include "cps_mmr_params.svh"

module cpsb_config (
    input  logic                   clk,
    input  logic                   cfg_we,
    input  logic [7:0]             cfg_data,
    output cps_mmr_pkg::cpsb_map_t map,
    output cps_mmr_pkg::mapper_t   mapper
);
    import cps_mmr_pkg::*;

    // byte 0 holds the first byte written once the string is complete
    logic [`CPSB_CFG_BYTES-1:0][7:0] cfg_q;

    // configuration bytes are byte addresses, the bus works in words
    function automatic logic [4:0] word_addr(input logic [7:0] byte_addr);
        return byte_addr[5:1];
    endfunction

    // survives reg_rst like the rest of the downloaded rom data
    always_ff @(posedge clk) begin
        if (cfg_we) begin
            cfg_q <= {cfg_data, cfg_q[`CPSB_CFG_BYTES-1:1]};
        end
    end

    // register address decode
    always_comb begin
        map.id       = word_addr(cfg_q[0]);
        map.mult1    = word_addr(cfg_q[2]);
        map.mult2    = word_addr(cfg_q[3]);
        map.rslt0    = word_addr(cfg_q[4]);
        map.rslt1    = word_addr(cfg_q[5]);
        map.layer    = word_addr(cfg_q[6]);
        map.prio0    = word_addr(cfg_q[7]);
        map.prio1    = word_addr(cfg_q[8]);
        map.prio2    = word_addr(cfg_q[9]);
        map.prio3    = word_addr(cfg_q[10]);
        map.in2      = word_addr(cfg_q[11]);
        map.in3      = word_addr(cfg_q[12]);
        map.pal_page = word_addr(cfg_q[13]);
    end

    // id, layer masks and rom mapper
    always_comb begin
        mapper.id          = cfg_q[1];
        mapper.mask0       = cfg_q[14];
        mapper.mask1       = cfg_q[15];
        mapper.mask2       = cfg_q[16];
        mapper.mask3       = cfg_q[17];
        // layer 4 has no byte of its own and shares the layer 3 mask
        mapper.mask4       = cfg_q[17];
        mapper.game        = cfg_q[18][5:0];
        // 16-bit fields arrive low byte first
        mapper.bank_offset = {cfg_q[20], cfg_q[19]};
        mapper.bank_mask   = {cfg_q[22], cfg_q[21]};
        mapper.cpu_speed   = cfg_q[23][0];
    end

    // an unknown byte shifted in would poison the decode for the whole game
    cfg_data_known: assert property (
        @(posedge clk) cfg_we |-> !$isunknown(cfg_data)
    ) else $error("cfg_data unknown while cfg_we is high");

endmodule

// ==== hdl/cps_a_regs.sv ====
`timescale 1ns/1ns
`include "cps_mmr_params.svh"

module cps_a_regs (
    input  logic                    clk,
    input  logic                    reg_rst,
    input  logic                    sel,
    input  cps_mmr_pkg::cpu_bus_t   bus,
    output cps_mmr_pkg::cps_a_out_t regs,
    output logic                    pal_copy,
    output logic                    obj_dma_ok
);
    import cps_mmr_pkg::*;

    typedef enum logic [4:0] {
        a_vram_obj   = 5'h00,
        a_vram1      = 5'h01,
        a_vram2      = 5'h02,
        a_vram3      = 5'h03,
        a_vram_row   = 5'h04,
        a_pal_base   = 5'h05,
        a_hpos1      = 5'h06,
        a_vpos1      = 5'h07,
        a_hpos2      = 5'h08,
        a_vpos2      = 5'h09,
        a_hpos3      = 5'h0a,
        a_vpos3      = 5'h0b,
        a_hstar1     = 5'h0c,
        a_vstar1     = 5'h0d,
        a_hstar2     = 5'h0e,
        a_vstar2     = 5'h0f,
        a_row_offset = 5'h10,
        a_ppu_ctrl   = 5'h11
    } cps_a_addr_e;

    cps_a_addr_e acc_addr;
    logic        copy_arm;
    logic        dma_arm;

    assign acc_addr = cps_a_addr_e'(bus.addr);

    // keep the old byte wherever its strobe is high
    function automatic logic [15:0] lane_merge(input logic [15:0] old_val,
                                               input logic [15:0] new_val,
                                               input logic [1:0]  dsn);
        return {dsn[1] ? old_val[15:8] : new_val[15:8],
                dsn[0] ? old_val[7:0]  : new_val[7:0]};
    endfunction

    always_ff @(posedge clk or posedge reg_rst) begin
        if (reg_rst) begin
            regs        <= '{default: `CPS_A_RST};
            pal_copy    <= 1'b0;
            obj_dma_ok  <= 1'b0;
            copy_arm    <= 1'b0;
            dma_arm     <= 1'b0;
        end else if (sel) begin
            pal_copy    <= 1'b0;
            // the latest access decides the dma flag
            dma_arm     <= (acc_addr == a_vram_obj);
            case (acc_addr)
                a_vram_obj:   regs.vram_obj_base <= lane_merge(regs.vram_obj_base, bus.data, bus.dsn);
                a_vram1:      regs.vram1_base    <= lane_merge(regs.vram1_base, bus.data, bus.dsn);
                a_vram2:      regs.vram2_base    <= lane_merge(regs.vram2_base, bus.data, bus.dsn);
                a_vram3:      regs.vram3_base    <= lane_merge(regs.vram3_base, bus.data, bus.dsn);
                a_vram_row:   regs.vram_row_base <= lane_merge(regs.vram_row_base, bus.data, bus.dsn);
                a_pal_base: begin
                    regs.pal_base <= lane_merge(regs.pal_base, bus.data, bus.dsn);
                    copy_arm      <= 1'b1;
                end
                a_hpos1:      regs.hpos1      <= lane_merge(regs.hpos1, bus.data, bus.dsn);
                a_vpos1:      regs.vpos1      <= lane_merge(regs.vpos1, bus.data, bus.dsn);
                a_hpos2:      regs.hpos2      <= lane_merge(regs.hpos2, bus.data, bus.dsn);
                a_vpos2:      regs.vpos2      <= lane_merge(regs.vpos2, bus.data, bus.dsn);
                a_hpos3:      regs.hpos3      <= lane_merge(regs.hpos3, bus.data, bus.dsn);
                a_vpos3:      regs.vpos3      <= lane_merge(regs.vpos3, bus.data, bus.dsn);
                a_hstar1:     regs.hstar1     <= lane_merge(regs.hstar1, bus.data, bus.dsn);
                a_vstar1:     regs.vstar1     <= lane_merge(regs.vstar1, bus.data, bus.dsn);
                a_hstar2:     regs.hstar2     <= lane_merge(regs.hstar2, bus.data, bus.dsn);
                a_vstar2:     regs.vstar2     <= lane_merge(regs.vstar2, bus.data, bus.dsn);
                a_row_offset: regs.row_offset <= lane_merge(regs.row_offset, bus.data, bus.dsn);
                a_ppu_ctrl:   regs.ppu_ctrl   <= lane_merge(regs.ppu_ctrl, bus.data, bus.dsn);
                default: ;
            endcase
        end else begin
            // pal_base is stable only once the select has dropped
            pal_copy   <= copy_arm;
            copy_arm   <= 1'b0;
            obj_dma_ok <= dma_arm;
        end
    end

    // one copy request per palette write burst
    pal_copy_single: assert property (
        @(posedge clk) disable iff (reg_rst) pal_copy |=> !pal_copy
    ) else $error("pal_copy high for more than one cycle");

endmodule

// ==== hdl/cps_b_regs.sv ====
`timescale 1ns/1ns
`include "cps_mmr_params.svh"

module cps_b_regs (
    input  logic                    clk,
    input  logic                    reg_rst,
    input  logic                    sel,
    input  cps_mmr_pkg::cpu_bus_t   bus,
    input  cps_mmr_pkg::cpsb_map_t  map,
    input  cps_mmr_pkg::mapper_t    mapper,
    input  cps_mmr_pkg::player_in_t players,
    output cps_mmr_pkg::cps_b_out_t regs,
    output logic [15:0]             rdata
);
    import cps_mmr_pkg::*;

    cpsb_reg_e   hit;
    logic [15:0] mult1;
    logic [15:0] mult2;
    logic [31:0] product;
    logic [7:0]  in2;
    logic [7:0]  in3;
    logic [15:0] rd_mux;
    logic        full_write;

    // multiplier and priority registers can be switched off per game
    function automatic logic match_opt(input logic [4:0] acc, input logic [4:0] reg_addr);
        return (acc == reg_addr) && (reg_addr != `CPSB_ADDR_OFF);
    endfunction

    // the extra input ports are absent when their address is 0
    function automatic logic match_in(input logic [4:0] acc, input logic [4:0] reg_addr);
        return (acc == reg_addr) && (reg_addr != 5'h00);
    endfunction

    // first match wins when a game maps two registers to one address
    always_comb begin
        hit = cpsb_none;
        if (bus.addr != `CPSB_ADDR_OFF) begin
            if (bus.addr == map.id)                  hit = cpsb_id;
            else if (match_opt(bus.addr, map.mult1)) hit = cpsb_mult1;
            else if (match_opt(bus.addr, map.mult2)) hit = cpsb_mult2;
            else if (match_opt(bus.addr, map.rslt0)) hit = cpsb_rslt0;
            else if (match_opt(bus.addr, map.rslt1)) hit = cpsb_rslt1;
            else if (bus.addr == map.layer)          hit = cpsb_layer;
            else if (match_opt(bus.addr, map.prio0)) hit = cpsb_prio0;
            else if (match_opt(bus.addr, map.prio1)) hit = cpsb_prio1;
            else if (match_opt(bus.addr, map.prio2)) hit = cpsb_prio2;
            else if (match_opt(bus.addr, map.prio3)) hit = cpsb_prio3;
            else if (bus.addr == map.pal_page)       hit = cpsb_pal_page;
            else if (match_in(bus.addr, map.in2))    hit = cpsb_in2;
            else if (match_in(bus.addr, map.in3))    hit = cpsb_in3;
        end
    end

    // extra players: start, coin and six joystick bits
    assign in2 = {players.start_button[2], players.coin_input[2], players.joystick3[5:0]};
    assign in3 = {players.start_button[3], players.coin_input[3], players.joystick4[5:0]};

    always_comb begin
        case (hit)
            cpsb_id:       rd_mux = {4'h0, mapper.id[7:4], 4'h0, mapper.id[3:0]};
            cpsb_mult1:    rd_mux = mult1;
            cpsb_mult2:    rd_mux = mult2;
            cpsb_rslt0:    rd_mux = product[15:0];
            cpsb_rslt1:    rd_mux = product[31:16];
            cpsb_layer:    rd_mux = regs.layer_ctrl;
            cpsb_prio0:    rd_mux = regs.prio0;
            cpsb_prio1:    rd_mux = regs.prio1;
            cpsb_prio2:    rd_mux = regs.prio2;
            cpsb_prio3:    rd_mux = regs.prio3;
            cpsb_pal_page: rd_mux = {10'd0, regs.pal_page_en};
            cpsb_in2:      rd_mux = {in2, in2};
            cpsb_in3:      rd_mux = {in3, in3};
            default:       rd_mux = `MMR_OPEN_BUS;
        endcase
    end

    // only full-word writes reach the cps_b registers
    assign full_write = sel && (bus.dsn == 2'b00);

    // operands and product carry no reset
    always_ff @(posedge clk) begin
        if (full_write && hit == cpsb_mult1) begin
            mult1 <= bus.data;
        end
        if (full_write && hit == cpsb_mult2) begin
            mult2 <= bus.data;
        end
        product <= {16'd0, mult1} * {16'd0, mult2};
    end

    always_ff @(posedge clk or posedge reg_rst) begin
        if (reg_rst) begin
            regs.layer_ctrl  <= `LAYER_CTRL_RST;
            regs.prio0       <= `PRIO_RST;
            regs.prio1       <= `PRIO_RST;
            regs.prio2       <= `PRIO_RST;
            regs.prio3       <= `PRIO_RST;
            regs.pal_page_en <= `PAL_PAGE_RST;
            rdata            <= `MMR_OPEN_BUS;
        end else begin
            if (sel) begin
                rdata <= rd_mux;
            end
            if (full_write) begin
                case (hit)
                    cpsb_layer:    regs.layer_ctrl  <= bus.data;
                    cpsb_prio0:    regs.prio0       <= bus.data;
                    cpsb_prio1:    regs.prio1       <= bus.data;
                    cpsb_prio2:    regs.prio2       <= bus.data;
                    cpsb_prio3:    regs.prio3       <= bus.data;
                    cpsb_pal_page: regs.pal_page_en <= bus.data[5:0];
                    default: ;
                endcase
            end
        end
    end

endmodule

// ==== hdl/cps_mmr_top.sv ====
`timescale 1ns/1ns

module cps_mmr_top (
    input  logic                    clk,
    input  logic                    reg_rst,
    input  logic                    ppu1_cs,
    input  logic                    ppu2_cs,
    input  cps_mmr_pkg::cpu_bus_t   bus,
    input  logic                    cfg_we,
    input  logic [7:0]              cfg_data,
    input  cps_mmr_pkg::player_in_t players,
    output logic [15:0]             mmr_dout,
    output cps_mmr_pkg::cps_a_out_t cps_a,
    output logic                    pal_copy,
    output logic                    obj_dma_ok,
    output cps_mmr_pkg::cps_b_out_t cps_b,
    output cps_mmr_pkg::mapper_t    mapper
);
    import cps_mmr_pkg::*;

    // per-game cps_b address map
    cpsb_map_t map;

    cpsb_config u_config (
        .clk      (clk),
        .cfg_we   (cfg_we),
        .cfg_data (cfg_data),
        .map      (map),
        .mapper   (mapper)
    );

    cps_a_regs u_cps_a (
        .clk        (clk),
        .reg_rst    (reg_rst),
        .sel        (ppu1_cs),
        .bus        (bus),
        .regs       (cps_a),
        .pal_copy   (pal_copy),
        .obj_dma_ok (obj_dma_ok)
    );

    cps_b_regs u_cps_b (
        .clk     (clk),
        .reg_rst (reg_rst),
        .sel     (ppu2_cs),
        .bus     (bus),
        .map     (map),
        .mapper  (mapper),
        .players (players),
        .regs    (cps_b),
        .rdata   (mmr_dout)
    );

    // both banks share one bus, so the cpu address decoder keeps them apart
    cs_exclusive: assert property (
        @(posedge clk) disable iff (reg_rst) !(ppu1_cs && ppu2_cs)
    ) else $error("ppu1_cs and ppu2_cs high together");

endmodule

// ==== verification/tb_clock.sv ====
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD = 100
) (
    output logic clk
);

    // free-running clock, low for the first half period
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

endmodule

// ==== verification/cps_mmr_tb.sv ====
`timescale 1ns/1ns
`include "cps_mmr_params.svh"

module cps_mmr_tb;
    import cps_mmr_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int DRV = 10;
    localparam int CFG_CYCLES = `CPSB_CFG_BYTES + 1;
    // reset, config, cps_a, pulses, multiplier, cps_b, inputs
    localparam int TEST_CYCLES = 12 + (CFG_CYCLES + 2) + 60 + 12 + (CFG_CYCLES + 12)
                                 + (2 * CFG_CYCLES + 30) + (CFG_CYCLES + 4);
    localparam int WATCHDOG_NS = (TEST_CYCLES + 100) * CLK_PERIOD;
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;

    // word addresses of the cps_b registers in the test map
    localparam logic [4:0] W_ID       = 5'h10;
    localparam logic [4:0] W_MULT1    = 5'h01;
    localparam logic [4:0] W_MULT2    = 5'h02;
    localparam logic [4:0] W_RSLT0    = 5'h03;
    localparam logic [4:0] W_RSLT1    = 5'h04;
    localparam logic [4:0] W_LAYER    = 5'h13;
    localparam logic [4:0] W_PRIO0    = 5'h14;
    localparam logic [4:0] W_PRIO2    = 5'h16;
    localparam logic [4:0] W_IN2      = 5'h18;
    localparam logic [4:0] W_IN3      = 5'h19;
    localparam logic [4:0] W_PAL_PAGE = 5'h1a;
    localparam logic [4:0] W_UNMAPPED = 5'h0c;

    logic        clk;
    logic        reg_rst;
    logic        ppu1_cs;
    logic        ppu2_cs;
    cpu_bus_t    bus;
    logic        cfg_we;
    logic [7:0]  cfg_data;
    player_in_t  players;
    logic [15:0] mmr_dout;
    cps_a_out_t  cps_a;
    logic        pal_copy;
    logic        obj_dma_ok;
    cps_b_out_t  cps_b;
    mapper_t     mapper;

    logic [7:0]  cfg_bytes [`CPSB_CFG_BYTES];
    logic [31:0] lfsr;
    int          errors;

    tb_clock #(.PERIOD(CLK_PERIOD)) clk_gen (.clk(clk));

    cps_mmr_top dut0 (
        .clk        (clk),
        .reg_rst    (reg_rst),
        .ppu1_cs    (ppu1_cs),
        .ppu2_cs    (ppu2_cs),
        .bus        (bus),
        .cfg_we     (cfg_we),
        .cfg_data   (cfg_data),
        .players    (players),
        .mmr_dout   (mmr_dout),
        .cps_a      (cps_a),
        .pal_copy   (pal_copy),
        .obj_dma_ok (obj_dma_ok),
        .cps_b      (cps_b),
        .mapper     (mapper)
    );

    // galois lfsr stepped once for every bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        b;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            b = lfsr[0];
            lfsr = lfsr >> 1;
            if (b) begin
                lfsr = lfsr ^ LFSR_TAPS;
            end
            v = {v[30:0], b};
        end
        return v;
    endfunction

    // config bytes carry byte addresses
    function automatic logic [7:0] addr_byte(input logic [4:0] w);
        return {2'b00, w, 1'b0};
    endfunction

    // slot in the cps_a struct for a word address
    // the struct groups the h and v positions
    function automatic int a_slot(input int addr);
        case (addr)
            7:       return 9;
            8:       return 7;
            9:       return 10;
            10:      return 8;
            13:      return 14;
            14:      return 13;
            default: return addr;
        endcase
    endfunction

    function automatic logic [15:0] a_field(input int addr);
        return cps_a[(17 - a_slot(addr)) * 16 +: 16];
    endfunction

    // index 0 is layer, 1 to 4 are prio0-3 and 5 is pal_page
    function automatic logic [4:0] b_addr(input int i);
        case (i)
            0:       return W_LAYER;
            5:       return W_PAL_PAGE;
            default: return W_PRIO0 + 5'(i - 1);
        endcase
    endfunction

    function automatic logic [15:0] b_field(input int i);
        case (i)
            0:       return cps_b.layer_ctrl;
            1:       return cps_b.prio0;
            2:       return cps_b.prio1;
            3:       return cps_b.prio2;
            4:       return cps_b.prio3;
            default: return {10'd0, cps_b.pal_page_en};
        endcase
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("Fail at %0t ns: %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #DRV;
    endtask

    task automatic bus_drive(input logic cs1, input logic cs2, input logic [4:0] addr,
                             input logic [1:0] dsn, input logic [15:0] data);
        ppu1_cs  = cs1;
        ppu2_cs  = cs2;
        bus.addr = addr;
        bus.dsn  = dsn;
        bus.data = data;
    endtask

    task automatic a_write(input logic [4:0] addr, input logic [15:0] data,
                           input logic [1:0] dsn);
        bus_drive(1'b1, 1'b0, addr, dsn, data);
        next_cycle();
        bus_drive(1'b0, 1'b0, 5'h00, 2'b11, 16'h0000);
    endtask

    task automatic b_write(input logic [4:0] addr, input logic [15:0] data,
                           input logic [1:0] dsn);
        bus_drive(1'b0, 1'b1, addr, dsn, data);
        next_cycle();
        bus_drive(1'b0, 1'b0, 5'h00, 2'b11, 16'h0000);
    endtask

    // read data is registered at the edge that samples the select
    task automatic b_read(input logic [4:0] addr, output logic [15:0] data);
        bus_drive(1'b0, 1'b1, addr, 2'b11, 16'h0000);
        next_cycle();
        data = mmr_dout;
        bus_drive(1'b0, 1'b0, 5'h00, 2'b11, 16'h0000);
    endtask

    // byte 0 goes in first and ends at the bottom
    task automatic cfg_load();
        int i;
        for (i = 0; i < `CPSB_CFG_BYTES; i++) begin
            cfg_we   = 1'b1;
            cfg_data = cfg_bytes[i];
            next_cycle();
        end
        cfg_we = 1'b0;
    endtask

    task automatic default_cfg();
        int i;
        cfg_bytes[0]  = addr_byte(W_ID);
        cfg_bytes[1]  = 8'(rand_bits(8));
        cfg_bytes[2]  = addr_byte(W_MULT1);
        cfg_bytes[3]  = addr_byte(W_MULT2);
        cfg_bytes[4]  = addr_byte(W_RSLT0);
        cfg_bytes[5]  = addr_byte(W_RSLT1);
        cfg_bytes[6]  = addr_byte(W_LAYER);
        for (i = 0; i < 4; i++) begin
            cfg_bytes[7 + i] = addr_byte(W_PRIO0 + 5'(i));
        end
        cfg_bytes[11] = addr_byte(W_IN2);
        cfg_bytes[12] = addr_byte(W_IN3);
        cfg_bytes[13] = addr_byte(W_PAL_PAGE);
        // masks and mapper fields
        for (i = 14; i < `CPSB_CFG_BYTES; i++) begin
            cfg_bytes[i] = 8'(rand_bits(8));
        end
    endtask

    task automatic reset_values();
        int i;
        for (i = 0; i < 18; i++) begin
            check($sformatf("cps_a[%02h]", i), 32'h0, 32'(a_field(i)));
        end
        check("cps_b.layer_ctrl", 32'(`LAYER_CTRL_RST), 32'(cps_b.layer_ctrl));
        for (i = 1; i < 5; i++) begin
            check($sformatf("cps_b.prio%0d", i - 1), 32'h0, 32'(b_field(i)));
        end
        check("cps_b.pal_page_en", 32'(`PAL_PAGE_RST), 32'(cps_b.pal_page_en));
        check("pal_copy", 32'h0, 32'(pal_copy));
        check("obj_dma_ok", 32'h0, 32'(obj_dma_ok));
        check("mmr_dout", 32'(`MMR_OPEN_BUS), 32'(mmr_dout));
    endtask

    task automatic config_decode();
        logic [15:0] rd;
        default_cfg();
        cfg_load();
        check("mapper.id", 32'(cfg_bytes[1]), 32'(mapper.id));
        check("mapper.mask0", 32'(cfg_bytes[14]), 32'(mapper.mask0));
        check("mapper.mask1", 32'(cfg_bytes[15]), 32'(mapper.mask1));
        check("mapper.mask2", 32'(cfg_bytes[16]), 32'(mapper.mask2));
        check("mapper.mask3", 32'(cfg_bytes[17]), 32'(mapper.mask3));
        check("mapper.mask4", 32'(cfg_bytes[17]), 32'(mapper.mask4));
        check("mapper.game", 32'(cfg_bytes[18][5:0]), 32'(mapper.game));
        check("mapper.bank_offset", 32'({cfg_bytes[20], cfg_bytes[19]}),
              32'(mapper.bank_offset));
        check("mapper.bank_mask", 32'({cfg_bytes[22], cfg_bytes[21]}), 32'(mapper.bank_mask));
        check("mapper.cpu_speed", 32'(cfg_bytes[23][0]), 32'(mapper.cpu_speed));
        b_read(W_ID, rd);
        check("mmr_dout id", 32'({4'h0, cfg_bytes[1][7:4], 4'h0, cfg_bytes[1][3:0]}), 32'(rd));
    endtask

    task automatic cps_a_writes();
        logic [15:0] model [18];
        logic [15:0] wdata;
        logic [1:0]  dsn;
        int          a;
        int          k;
        int          f;
        for (f = 0; f < 18; f++) begin
            model[f] = 16'h0000;
        end
        for (k = 0; k < 3; k++) begin
            dsn = (k == 0) ? 2'b00 : ((k == 1) ? 2'b01 : 2'b10);
            for (a = 0; a < 18; a++) begin
                wdata = 16'(rand_bits(16));
                a_write(5'(a), wdata, dsn);
                if (!dsn[1]) begin
                    model[a][15:8] = wdata[15:8];
                end
                if (!dsn[0]) begin
                    model[a][7:0] = wdata[7:0];
                end
                for (f = 0; f < 18; f++) begin
                    check($sformatf("cps_a[%02h]", f), 32'(model[f]), 32'(a_field(f)));
                end
            end
        end
    endtask

    task automatic copy_pulses();
        // palette write inside a two-cycle select burst
        bus_drive(1'b1, 1'b0, 5'h05, 2'b00, 16'(rand_bits(16)));
        next_cycle();
        check("pal_copy", 32'h0, 32'(pal_copy));
        bus_drive(1'b1, 1'b0, 5'h07, 2'b00, 16'(rand_bits(16)));
        next_cycle();
        check("pal_copy", 32'h0, 32'(pal_copy));
        bus_drive(1'b0, 1'b0, 5'h00, 2'b11, 16'h0000);
        next_cycle();
        check("pal_copy", 32'h1, 32'(pal_copy));
        check("obj_dma_ok", 32'h0, 32'(obj_dma_ok));
        next_cycle();
        check("pal_copy", 32'h0, 32'(pal_copy));
        a_write(5'h00, 16'(rand_bits(16)), 2'b00);
        check("obj_dma_ok", 32'h0, 32'(obj_dma_ok));
        next_cycle();
        check("obj_dma_ok", 32'h1, 32'(obj_dma_ok));
        check("pal_copy", 32'h0, 32'(pal_copy));
        repeat (2) next_cycle();
        check("obj_dma_ok", 32'h1, 32'(obj_dma_ok));
        a_write(5'h0c, 16'(rand_bits(16)), 2'b00);
        next_cycle();
        check("obj_dma_ok", 32'h0, 32'(obj_dma_ok));
    endtask

    task automatic multiplier_reads();
        logic [15:0] m1;
        logic [15:0] m2;
        logic [31:0] prod;
        logic [15:0] rd;
        default_cfg();
        cfg_load();
        m1 = 16'(rand_bits(16));
        m2 = 16'(rand_bits(16));
        prod = {16'd0, m1} * {16'd0, m2};
        b_write(W_MULT1, m1, 2'b00);
        b_write(W_MULT2, m2, 2'b00);
        repeat (2) next_cycle();
        b_read(W_RSLT0, rd);
        check("mmr_dout rslt0", 32'(prod[15:0]), 32'(rd));
        b_read(W_RSLT1, rd);
        check("mmr_dout rslt1", 32'(prod[31:16]), 32'(rd));
        b_read(W_MULT1, rd);
        check("mmr_dout mult1", 32'(m1), 32'(rd));
        b_read(W_MULT2, rd);
        check("mmr_dout mult2", 32'(m2), 32'(rd));
    endtask

    task automatic cps_b_access();
        logic [15:0] last [6];
        logic [15:0] d;
        logic [15:0] rd;
        int          i;
        default_cfg();
        cfg_load();
        for (i = 0; i < 6; i++) begin
            d = 16'(rand_bits(16));
            last[i] = (i == 5) ? {10'd0, d[5:0]} : d;
            b_write(b_addr(i), d, 2'b00);
            check($sformatf("cps_b reg %0d", i), 32'(last[i]), 32'(b_field(i)));
            b_read(b_addr(i), rd);
            check($sformatf("mmr_dout reg %0d", i), 32'(last[i]), 32'(rd));
        end
        // a single byte strobe leaves cps_b alone
        b_write(W_LAYER, ~last[0], 2'b01);
        b_write(W_PRIO0 + 5'd1, ~last[2], 2'b10);
        check("cps_b.layer_ctrl", 32'(last[0]), 32'(b_field(0)));
        check("cps_b.prio1", 32'(last[2]), 32'(b_field(2)));
        // prio2 switched off for this game
        cfg_bytes[9] = addr_byte(`CPSB_ADDR_OFF);
        cfg_load();
        b_write(`CPSB_ADDR_OFF, ~last[3], 2'b00);
        check("cps_b.prio2", 32'(last[3]), 32'(b_field(3)));
        b_read(`CPSB_ADDR_OFF, rd);
        check("mmr_dout at 1f", 32'(`MMR_OPEN_BUS), 32'(rd));
        b_read(W_PRIO2, rd);
        check("mmr_dout at old prio2", 32'(`MMR_OPEN_BUS), 32'(rd));
        b_read(W_UNMAPPED, rd);
        check("mmr_dout unmapped", 32'(`MMR_OPEN_BUS), 32'(rd));
    endtask

    task automatic extra_inputs();
        logic [3:0]  start;
        logic [3:0]  coin;
        logic [7:0]  joy3;
        logic [7:0]  joy4;
        logic [7:0]  p2;
        logic [7:0]  p3;
        logic [15:0] rd;
        default_cfg();
        cfg_load();
        start   = 4'(rand_bits(4));
        coin    = 4'(rand_bits(4));
        joy3    = 8'(rand_bits(8));
        joy4    = 8'(rand_bits(8));
        players = {start, coin, joy3, joy4};
        // each byte holds start, coin and joystick bits 5:0
        p2 = {start[2], coin[2], joy3[5:0]};
        p3 = {start[3], coin[3], joy4[5:0]};
        b_read(W_IN2, rd);
        check("mmr_dout in2", 32'({p2, p2}), 32'(rd));
        b_read(W_IN3, rd);
        check("mmr_dout in3", 32'({p3, p3}), 32'(rd));
    endtask

    initial begin
        errors   = 0;
        lfsr     = 32'he815;
        reg_rst  = 1'b1;
        cfg_we   = 1'b0;
        cfg_data = 8'h00;
        players  = '0;
        bus_drive(1'b0, 1'b0, 5'h00, 2'b11, 16'h0000);
        repeat (8) @(posedge clk);
        #DRV;
        reg_rst = 1'b0;
        reset_values();
        next_cycle();
        reset_values();
        config_decode();
        cps_a_writes();
        copy_pulses();
        multiplier_reads();
        cps_b_access();
        extra_inputs();
        $display("error count: %0d", errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: tests still running after %0d cycles", WATCHDOG_NS / CLK_PERIOD);
        $display("Checks failed");
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+hdl
hdl/cps_mmr_pkg.sv
hdl/cpsb_config.sv
hdl/cps_a_regs.sv
hdl/cps_b_regs.sv
hdl/cps_mmr_top.sv
verification/tb_clock.sv
verification/cps_mmr_tb.sv

// ==== Makefile ====
# Verilator build and run of the register subsystem testbench

VERILATOR ?= verilator
TOP       ?= cps_mmr_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

PASS_MSG  := All checks passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run $(TOP), search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
